//--- bcd_macros.svh
/* Widths, register map and status bit positions of the binary to BCD peripheral.
   Included by the package and by every module that sizes a port or decodes an address. */
`ifndef BCD_MACROS_SVH
`define BCD_MACROS_SVH

// --------------------
// Datapath widths
// --------------------

// Binary operand width
`define BCD_BIN_WIDTH 16
// Packed BCD digits in a result
`define BCD_DIGITS 5
// Bit counter, must hold BCD_BIN_WIDTH
`define BCD_CNT_WIDTH 5
// Significant-digit count, must hold BCD_DIGITS
`define BCD_NDIG_WIDTH 3

// --------------------
// Wishbone register map
// --------------------

`define BCD_WB_DW 32
// Word indices, taken from adr[3:2]
`define BCD_ADDR_OPERAND 0
`define BCD_ADDR_STATUS 1
`define BCD_ADDR_RESULT 2
`define BCD_ADDR_NDIGITS 3

// Status word bit positions
`define BCD_ST_BUSY 0
`define BCD_ST_DONE 1
`define BCD_ST_OVERRUN 2

`endif

//--- bcd_pkg.sv
/* Shared types of the binary to BCD peripheral: the result word and the register indices.
   Modules name them as bcd_pkg::name in port lists and import the package in their bodies. */
`include "bcd_macros.svh"

package bcd_pkg;

    // --------------------
    // Result word
    // --------------------

    // Five BCD digits, least significant digit in the low nibble
    // Digit view for the datapath, raw view for the bus
    typedef union packed {
        logic [`BCD_DIGITS-1:0][3:0] digit;
        logic [`BCD_DIGITS*4-1:0]    raw;
    } bcd_word_u;

    // --------------------
    // Register indices
    // --------------------

    // Decoded from adr[3:2]
    typedef enum logic [1:0] {
        REG_OPERAND = 2'(`BCD_ADDR_OPERAND),
        REG_STATUS  = 2'(`BCD_ADDR_STATUS),
        REG_RESULT  = 2'(`BCD_ADDR_RESULT),
        REG_NDIGITS = 2'(`BCD_ADDR_NDIGITS)
    } bcd_reg_e;

endpackage

//--- bcd_bus_decode.sv
/* Wishbone classic slave of the BCD peripheral: address decode, single-cycle ack,
   strobes towards the engine and result store, and the registered read-data mux. */
`include "bcd_macros.svh"

module bcd_bus_decode (
    input  logic                        clk,
    input  logic                        arst_n,
    // Wishbone classic slave side
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [`BCD_WB_DW-1:0]       adr,
    input  logic [`BCD_WB_DW-1:0]       dat_w,
    output logic [`BCD_WB_DW-1:0]       dat_r,
    output logic                        ack,
    // Engine side
    input  logic                        busy,
    output logic                        start,
    output logic [`BCD_BIN_WIDTH-1:0]   operand,
    // Result store side
    input  bcd_pkg::bcd_word_u          result,
    input  logic                        done,
    input  logic                        overrun,
    input  logic [`BCD_NDIG_WIDTH-1:0]  ndigits,
    output logic                        overrun_set,
    output logic                        result_read,
    output logic                        status_read
);
    import bcd_pkg::*;

    logic                  access;
    logic                  mapped;
    bcd_reg_e              reg_idx;
    logic [`BCD_WB_DW-1:0] status_word;
    logic [`BCD_WB_DW-1:0] rdata_d;

    // --------------------
    // Access qualification
    // --------------------

    // Cycle active and not yet acked, ack lands on the next edge
    assign access = cyc & stb & ~ack;

    // Only the first four words are mapped
    assign mapped = (adr[`BCD_WB_DW-1:4] == '0);
    assign reg_idx = bcd_reg_e'(adr[3:2]);

    // Operand goes straight from the bus, engine samples it with start
    assign operand = dat_w[`BCD_BIN_WIDTH-1:0];

    // --------------------
    // Strobes
    // --------------------

    always_comb begin
        start       = 1'b0;
        overrun_set = 1'b0;
        result_read = 1'b0;
        status_read = 1'b0;
        if (access && mapped) begin
            if (we) begin
                // Operand write starts a conversion, or flags overrun if one is running
                if (reg_idx == REG_OPERAND) begin
                    start       = ~busy;
                    overrun_set = busy;
                end
            end else begin
                // Reads that clear sticky flags
                result_read = (reg_idx == REG_RESULT);
                status_read = (reg_idx == REG_STATUS);
            end
        end
    end

    // --------------------
    // Read data
    // --------------------

    // Status bits, rest reads zero
    always_comb begin
        status_word                  = '0;
        status_word[`BCD_ST_BUSY]    = busy;
        status_word[`BCD_ST_DONE]    = done;
        status_word[`BCD_ST_OVERRUN] = overrun;
    end

    always_comb begin
        rdata_d = '0;
        if (mapped) begin
            case (reg_idx)
                REG_STATUS:  rdata_d = status_word;
                // Bus sees the raw view of the result
                REG_RESULT:  rdata_d[`BCD_DIGITS*4-1:0] = result.raw;
                REG_NDIGITS: rdata_d[`BCD_NDIG_WIDTH-1:0] = ndigits;
                // Operand is write only
                default:     rdata_d = '0;
            endcase
        end
    end

    // Ack and read data registered together, data is valid while ack is high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack   <= 1'b0;
            dat_r <= '0;
        end else begin
            ack   <= access;
            dat_r <= (access && !we) ? rdata_d : '0;
        end
    end

endmodule

//--- bcd_dabble_engine.sv
/* Sequential double-dabble converter: loads a binary operand on start, then runs one
   add-3 pass and one left shift per clock, pulsing finish with the digits on the last step. */
`include "bcd_macros.svh"

module bcd_dabble_engine (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  logic [`BCD_BIN_WIDTH-1:0]  operand,
    output logic                       busy,
    output logic                       finish,
    output bcd_pkg::bcd_word_u         digits
);
    import bcd_pkg::*;

    // Digit nibbles sit above the binary bits
    localparam int BCD_W   = `BCD_DIGITS * 4;
    localparam int SHIFT_W = BCD_W + `BCD_BIN_WIDTH;

    logic [SHIFT_W-1:0]         shift_q;
    logic [SHIFT_W-1:0]         shift_d;
    logic [`BCD_CNT_WIDTH-1:0]  cnt_q;
    bcd_word_u                  adj;
    logic                       last_step;

    // --------------------
    // One conversion step
    // --------------------

    always_comb begin
        // Digit part of the register through the digit view
        adj = shift_q[SHIFT_W-1 -: BCD_W];
        // Add 3 where a digit would overflow past 9 after doubling
        for (int i = 0; i < `BCD_DIGITS; i++) begin
            if (adj.digit[i] > 4'd4) begin
                adj.digit[i] = adj.digit[i] + 4'd3;
            end
        end
        // Whole register moves left by one, next binary bit enters the digits
        shift_d = {adj.raw[BCD_W-2:0], shift_q[`BCD_BIN_WIDTH-1:0], 1'b0};
    end

    // Counter reaches 1 on the cycle before the final edge
    assign last_step = busy && (cnt_q == `BCD_CNT_WIDTH'(1));

    // Finish comes with the digits of the last step, captured on that edge
    assign finish = last_step;
    assign digits.raw = shift_d[SHIFT_W-1 -: BCD_W];

    // --------------------
    // Control
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            cnt_q <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            cnt_q <= `BCD_CNT_WIDTH'(`BCD_BIN_WIDTH);
        end else if (busy) begin
            cnt_q <= cnt_q - `BCD_CNT_WIDTH'(1);
            // Drop busy on the edge of the last step
            if (last_step) begin
                busy <= 1'b0;
            end
        end
    end

    // --------------------
    // Shift register
    // --------------------

    // Payload only, qualified by busy
    always_ff @(posedge clk) begin
        if (start) begin
            // Operand in the low bits, all digits zero
            shift_q <= {{BCD_W{1'b0}}, operand};
        end else if (busy) begin
            shift_q <= shift_d;
        end
    end

endmodule

//--- bcd_result_store.sv
/* Holds the last finished BCD result with its significant-digit count, and keeps the
   sticky done and overrun flags that the bus reads back through the status word. */
`include "bcd_macros.svh"

module bcd_result_store (
    input  logic                        clk,
    input  logic                        arst_n,
    // From the engine
    input  logic                        finish,
    input  bcd_pkg::bcd_word_u          digits,
    // From the bus decode
    input  logic                        result_read,
    input  logic                        status_read,
    input  logic                        overrun_set,
    // Towards the bus decode
    output bcd_pkg::bcd_word_u          result,
    output logic                        done,
    output logic [`BCD_NDIG_WIDTH-1:0]  ndigits,
    output logic                        overrun
);

    logic [`BCD_NDIG_WIDTH-1:0] ndigits_d;

    // --------------------
    // Significant digits
    // --------------------

    // Highest nonzero digit position plus one, zero still counts as one digit
    always_comb begin
        ndigits_d = `BCD_NDIG_WIDTH'(1);
        for (int i = 1; i < `BCD_DIGITS; i++) begin
            if (digits.digit[i] != 4'd0) begin
                ndigits_d = `BCD_NDIG_WIDTH'(i + 1);
            end
        end
    end

    // --------------------
    // Result and flags
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result  <= '0;
            ndigits <= `BCD_NDIG_WIDTH'(1);
            done    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            // Result and count captured together on finish
            if (finish) begin
                result  <= digits;
                ndigits <= ndigits_d;
            end
            // New result wins over a read in the same cycle
            if (finish) begin
                done <= 1'b1;
            end else if (result_read) begin
                done <= 1'b0;
            end
            // Sticky until the status word has been read
            if (overrun_set) begin
                overrun <= 1'b1;
            end else if (status_read) begin
                overrun <= 1'b0;
            end
        end
    end

endmodule

//--- bcd_wb_top.sv
/* Top level of the Wishbone binary to BCD peripheral.
   Connects the bus decode, the double-dabble engine and the result store. */
`include "bcd_macros.svh"

module bcd_wb_top (
    input  logic                   clk,
    input  logic                   arst_n,
    // Wishbone classic slave
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`BCD_WB_DW-1:0]  adr,
    input  logic [`BCD_WB_DW-1:0]  dat_w,
    output logic [`BCD_WB_DW-1:0]  dat_r,
    output logic                   ack
);
    import bcd_pkg::*;

    // Decode to engine
    logic                       start;
    logic [`BCD_BIN_WIDTH-1:0]  operand;
    // Engine to result store
    logic                       busy;
    logic                       finish;
    bcd_word_u                  eng_digits;
    // Result store and decode
    bcd_word_u                  held_result;
    logic                       done;
    logic                       overrun;
    logic [`BCD_NDIG_WIDTH-1:0] ndigits;
    logic                       overrun_set;
    logic                       result_read;
    logic                       status_read;

    // --------------------
    // Decode
    // --------------------

    bcd_bus_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .busy        (busy),
        .start       (start),
        .operand     (operand),
        .result      (held_result),
        .done        (done),
        .overrun     (overrun),
        .ndigits     (ndigits),
        .overrun_set (overrun_set),
        .result_read (result_read),
        .status_read (status_read)
    );

    // --------------------
    // Execute
    // --------------------

    bcd_dabble_engine u_engine (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .operand (operand),
        .busy    (busy),
        .finish  (finish),
        .digits  (eng_digits)
    );

    // --------------------
    // Result
    // --------------------

    bcd_result_store u_store (
        .clk         (clk),
        .arst_n      (arst_n),
        .finish      (finish),
        .digits      (eng_digits),
        .result_read (result_read),
        .status_read (status_read),
        .overrun_set (overrun_set),
        .result      (held_result),
        .done        (done),
        .ndigits     (ndigits),
        .overrun     (overrun)
    );

endmodule

//--- tb_bcd_wb.sv
/* Testbench of the Wishbone binary to BCD peripheral.
   Runs classic bus cycles into the top level and checks every read against a decimal model. */
`include "bcd_macros.svh"

module tb_bcd_wb;

    logic        clk;
    logic        arst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    // Bookkeeping
    int unsigned cycle_cnt = 0;
    int          pass_cnt;
    int          fail_cnt;
    int          test_fails;
    logic [31:0] lfsr_state;

    // Directed operands, edges of every digit count
    logic [15:0] dir_ops [8] = '{16'd0, 16'd9, 16'd10, 16'd99, 16'd100, 16'd4095,
                                 16'd65535, 16'd10000};

    bcd_wb_top UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack)
    );

    // Clock, period 100
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Cycle count for the done poll limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // --------------------
    // Models
    // --------------------

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // Decimal digits by repeated division by ten, digit count returned in ndig
    function automatic logic [19:0] bcd_model(input logic [15:0] bin,
                                              output logic [2:0] ndig);
        logic [19:0] digits_d;
        int          v;
        int          n;
        v = bin;
        digits_d = '0;
        for (int i = 0; i < 5; i++) begin
            digits_d[i*4 +: 4] = 4'(v % 10);
            v = v / 10;
        end
        // Count of decimal places, zero is one place
        v = bin;
        n = 1;
        while (v >= 10) begin
            n++;
            v = v / 10;
        end
        ndig = 3'(n);
        return digits_d;
    endfunction

    // One LFSR step per operand bit
    task automatic next_operand(output logic [15:0] op);
        op = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            op = {op[14:0], lfsr_state[0]};
        end
    endtask

    // --------------------
    // Checking
    // --------------------

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h, got %h",
                     $time, what, expected, actual);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Error at time %0t: %s did not complete within its time limit", $time, what);
        fail_cnt++;
    endtask

    // One line per finished test
    task automatic end_test(input string name);
        if (fail_cnt == test_fails) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, fail_cnt - test_fails);
        end
        test_fails = fail_cnt;
    endtask

    // --------------------
    // Bus driver
    // --------------------

    // Called on a falling edge, returns on the falling edge that sees ack
    task automatic wb_write(input int idx, input logic [31:0] data);
        int   waited;
        logic got;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = 32'(idx) << 2;
        dat_w = data;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < 20) begin
            @(negedge clk);
            waited++;
            got = ack;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        if (!got) begin
            report_timeout("Bus write");
        end
    endtask

    // Read data taken at the falling edge, halfway through ack
    task automatic wb_read(input int idx, output logic [31:0] data);
        int   waited;
        logic got;
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = 1'b0;
        adr  = 32'(idx) << 2;
        data = '0;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < 20) begin
            @(negedge clk);
            waited++;
            got = ack;
        end
        if (got) begin
            data = dat_r;
        end
        cyc = 1'b0;
        stb = 1'b0;
        if (!got) begin
            report_timeout("Bus read");
        end
    endtask

    // Poll STATUS until done, 40 cycles at most
    task automatic wait_done();
        int unsigned t0;
        logic [31:0] st;
        t0 = cycle_cnt;
        st = '0;
        while (!st[`BCD_ST_DONE] && (cycle_cnt - t0) < 40) begin
            wb_read(`BCD_ADDR_STATUS, st);
        end
        if (!st[`BCD_ST_DONE]) begin
            report_timeout("Conversion");
        end
    endtask

    // Full conversion with RESULT and NDIGITS checked
    task automatic convert_check(input logic [15:0] op);
        logic [19:0] exp_d;
        logic [2:0]  exp_n;
        logic [31:0] rd;
        exp_d = bcd_model(op, exp_n);
        wb_write(`BCD_ADDR_OPERAND, {16'h0, op});
        wait_done();
        wb_read(`BCD_ADDR_RESULT, rd);
        compare_word($sformatf("RESULT of %0d", op), {12'h0, exp_d}, rd);
        wb_read(`BCD_ADDR_NDIGITS, rd);
        compare_word($sformatf("NDIGITS of %0d", op), {29'h0, exp_n}, rd);
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        logic [31:0] rd;
        logic [15:0] op;
        logic [19:0] keep_d;
        logic [2:0]  keep_n;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        arst_n     = 1'b0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        test_fails = 0;
        lfsr_state = 32'hdbc53df8;
        // Reset for 10 cycles
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Reset values
        wb_read(`BCD_ADDR_STATUS, rd);
        compare_word("STATUS after reset", 32'h0, rd);
        wb_read(`BCD_ADDR_RESULT, rd);
        compare_word("RESULT after reset", 32'h0, rd);
        wb_read(`BCD_ADDR_NDIGITS, rd);
        compare_word("NDIGITS after reset", 32'h1, rd);
        end_test("reset state");

        foreach (dir_ops[i]) begin
            convert_check(dir_ops[i]);
        end
        end_test("directed conversions");

        for (int n = 0; n < 200; n++) begin
            next_operand(op);
            convert_check(op);
        end
        end_test("random conversions");

        // Busy right after the write, done gone after RESULT read
        wb_write(`BCD_ADDR_OPERAND, 32'd1234);
        wb_read(`BCD_ADDR_STATUS, rd);
        compare_word("STATUS busy after write", 32'h1, {31'h0, rd[`BCD_ST_BUSY]});
        wait_done();
        wb_read(`BCD_ADDR_RESULT, rd);
        wb_read(`BCD_ADDR_STATUS, rd);
        compare_word("STATUS done after RESULT read", 32'h0, {31'h0, rd[`BCD_ST_DONE]});
        end_test("done flag");

        // Second write lands while the first conversion runs
        keep_d = bcd_model(16'd4321, keep_n);
        wb_write(`BCD_ADDR_OPERAND, 32'd4321);
        wb_write(`BCD_ADDR_OPERAND, 32'd777);
        wb_read(`BCD_ADDR_STATUS, rd);
        compare_word("STATUS overrun set", 32'h1, {31'h0, rd[`BCD_ST_OVERRUN]});
        wb_read(`BCD_ADDR_STATUS, rd);
        compare_word("STATUS overrun cleared", 32'h0, {31'h0, rd[`BCD_ST_OVERRUN]});
        wait_done();
        wb_read(`BCD_ADDR_RESULT, rd);
        compare_word("RESULT kept after overrun", {12'h0, keep_d}, rd);
        wb_read(`BCD_ADDR_NDIGITS, rd);
        compare_word("NDIGITS kept after overrun", {29'h0, keep_n}, rd);
        end_test("overrun");

        // Word 5 is outside the map and shares adr[3:2] with STATUS
        // Done is left set, so a read that aliased STATUS would come back nonzero
        keep_d = bcd_model(16'd802, keep_n);
        wb_write(`BCD_ADDR_OPERAND, 32'd802);
        wait_done();
        wb_read(5, rd);
        compare_word("unmapped read", 32'h0, rd);
        wb_write(5, 32'h0000_ffff);
        wb_read(`BCD_ADDR_STATUS, rd);
        compare_word("STATUS idle after unmapped write", 32'h0, {31'h0, rd[`BCD_ST_BUSY]});
        // Longer than one conversion, a wrongly started one would have landed by now
        repeat (20) @(negedge clk);
        wb_read(`BCD_ADDR_RESULT, rd);
        compare_word("RESULT after unmapped write", {12'h0, keep_d}, rd);
        end_test("unmapped address");

        $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+.
bcd_pkg.sv
bcd_bus_decode.sv
bcd_dabble_engine.sv
bcd_result_store.sv
bcd_wb_top.sv
tb_bcd_wb.sv

//--- Bender.yml
package:
  name: bcd_wb

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - bcd_pkg.sv
      - bcd_bus_decode.sv
      - bcd_dabble_engine.sv
      - bcd_result_store.sv
      - bcd_wb_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_bcd_wb.sv
